// File: hdl/adc_pkg.sv
`default_nettype none

package adc_pkg;

    typedef logic [3:0]  nibble_t;
    typedef logic [11:0] addr_t;
    typedef logic [11:0] instr_t;

    // Order follows the r/q operand code
    typedef enum logic [1:0] {
        OP_A,
        OP_B,
        OP_MX,
        OP_MY
    } operand_e;

    typedef enum logic [2:0] {
        CLS_IDX_IMM,
        CLS_RQ,
        CLS_RI,
        CLS_ACP,
        CLS_ILLEGAL
    } op_class_e;

    // XH/XL are bits 7:4 and 3:0 of X and YH/YL the same bits of Y
    typedef enum logic [1:0] {
        XH,
        XL,
        YH,
        YL
    } idx_field_e;

    typedef struct packed {
        op_class_e  cls;
        operand_e   dst;
        operand_e   src;
        idx_field_e idx_field;
        nibble_t    imm;
        logic       use_imm;
        logic       use_decimal;
        logic       inc_x;
        logic       inc_y;
    } op_desc_t;

    typedef struct packed {
        nibble_t a;
        nibble_t b;
        addr_t   x;
        addr_t   y;
        logic    carry;
        logic    zero;
        logic    decimal;
    } arch_state_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_DECODE,
        S_READ,
        S_ADD,
        S_WRITE,
        S_INC,
        S_DONE
    } seq_state_e;

endpackage

`default_nettype wire

// File: hdl/opcode_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module opcode_decoder (
    input  adc_pkg::instr_t   instr,
    output adc_pkg::op_desc_t desc
);
    import adc_pkg::*;

    always_comb begin
        desc     = '0;
        desc.cls = CLS_ILLEGAL;

        if (instr[11:6] == 6'b1010_00) begin
            // ADC XH/XL/YH/YL,i
            desc.cls       = CLS_IDX_IMM;
            desc.idx_field = idx_field_e'(instr[5:4]);
            desc.imm       = instr[3:0];
            desc.use_imm   = 1'b1;
        end else if (instr[11:4] == 8'hA9) begin
            // ADC r,q
            desc.cls         = CLS_RQ;
            desc.dst         = operand_e'(instr[3:2]);
            desc.src         = operand_e'(instr[1:0]);
            desc.use_decimal = 1'b1;
        end else if (instr[11:6] == 6'b1100_01) begin
            // ADC r,i
            desc.cls         = CLS_RI;
            desc.dst         = operand_e'(instr[5:4]);
            desc.imm         = instr[3:0];
            desc.use_imm     = 1'b1;
            desc.use_decimal = 1'b1;
        end else if (instr[11:3] == 9'b1111_0010_1) begin
            // ACPX MX,r and ACPY MY,r with bit 2 picking Y
            desc.cls         = CLS_ACP;
            desc.dst         = instr[2] ? OP_MY : OP_MX;
            desc.src         = operand_e'(instr[1:0]);
            desc.use_decimal = 1'b1;
            desc.inc_x       = !instr[2];
            desc.inc_y       = instr[2];
        end
    end

endmodule

`default_nettype wire

// File: hdl/bcd_adder.sv
`timescale 1ns/10ps
`default_nettype none

module bcd_adder (
    input  adc_pkg::nibble_t a,
    input  adc_pkg::nibble_t b,
    input  logic             carry_in,
    input  logic             decimal,
    output adc_pkg::nibble_t sum,
    output logic             carry_out,
    output logic             zero
);
    import adc_pkg::*;

    logic [4:0] raw;
    logic [4:0] wrapped;
    logic       dec_wrap;

    assign raw      = {1'b0, a} + {1'b0, b} + {4'b0, carry_in};
    assign wrapped  = raw - 5'd10;
    assign dec_wrap = decimal && (raw >= 5'd10);

    assign sum       = dec_wrap ? wrapped[3:0] : raw[3:0];
    assign carry_out = dec_wrap || raw[4];  // raw[4] implies wrap in decimal
    assign zero      = (sum == nibble_t'(0));

    // Non-BCD operands give an undefined decimal result
    always_comb begin
        if (decimal) begin
            assert (a <= 4'd9 && b <= 4'd9)
                else $error("non-BCD operand in decimal mode: a=%h b=%h", a, b);
        end
    end

endmodule

`default_nettype wire

// File: hdl/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load_valid,
    input  adc_pkg::arch_state_t state_in,
    input  logic                 wb_en,
    input  adc_pkg::operand_e    wb_dst,
    input  logic                 wb_idx_en,
    input  adc_pkg::idx_field_e  wb_idx_field,
    input  adc_pkg::nibble_t     wb_data,
    input  logic                 flag_en,
    input  logic                 carry_in,
    input  logic                 zero_in,
    input  logic                 inc_x,
    input  logic                 inc_y,
    output adc_pkg::arch_state_t state
);
    import adc_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= '0;
        end else if (load_valid) begin  // Host load wins
            state <= state_in;
        end else begin
            if (wb_en) begin
                if (wb_dst == OP_A) begin
                    state.a <= wb_data;
                end else if (wb_dst == OP_B) begin
                    state.b <= wb_data;
                end
            end
            if (wb_idx_en) begin
                case (wb_idx_field)
                    XH:      state.x[7:4] <= wb_data;
                    XL:      state.x[3:0] <= wb_data;
                    YH:      state.y[7:4] <= wb_data;
                    default: state.y[3:0] <= wb_data;
                endcase
            end
            if (flag_en) begin
                state.carry <= carry_in;
                state.zero  <= zero_in;
            end
            if (inc_x)
                state.x <= state.x + addr_t'(1);  // FFF wraps to 000
            if (inc_y)
                state.y <= state.y + addr_t'(1);
        end
    end

    // Decoder marks only one index per ACP opcode
    assert property (@(posedge clk) disable iff (reset) !(inc_x && inc_y))
        else $error("inc_x and inc_y high together");

endmodule

`default_nettype wire

// File: hdl/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module data_ram #(
    parameter int MEM_DEPTH = 4096
) (
    input  logic             clk,
    input  logic             we,
    input  adc_pkg::addr_t   waddr,
    input  adc_pkg::nibble_t wdata,
    input  adc_pkg::addr_t   raddr,
    output adc_pkg::nibble_t rdata
);
    import adc_pkg::*;

    localparam int AW = $clog2(MEM_DEPTH);

    nibble_t       mem [MEM_DEPTH];
    logic [AW-1:0] wa;
    logic [AW-1:0] ra;

    // Upper address bits dropped, so addresses wrap
    assign wa = waddr[AW-1:0];
    assign ra = raddr[AW-1:0];

    always_ff @(posedge clk) begin
        if (we)
            mem[wa] <= wdata;
        rdata <= mem[ra];  // Old data on same-address write
    end

endmodule

`default_nettype wire

// File: hdl/exec_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module exec_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_valid,
    output logic                 instr_ready,
    output logic                 done,
    input  adc_pkg::op_desc_t    desc,
    input  adc_pkg::arch_state_t state,
    output adc_pkg::addr_t       mem_raddr,
    input  adc_pkg::nibble_t     mem_rdata,
    output logic                 mem_we,
    output adc_pkg::addr_t       mem_waddr,
    output adc_pkg::nibble_t     mem_wdata,
    output adc_pkg::nibble_t     add_a,
    output adc_pkg::nibble_t     add_b,
    output logic                 add_decimal,
    input  adc_pkg::nibble_t     add_sum,
    input  logic                 add_carry,
    input  logic                 add_zero,
    output logic                 wb_en,
    output adc_pkg::operand_e    wb_dst,
    output logic                 wb_idx_en,
    output adc_pkg::idx_field_e  wb_idx_field,
    output adc_pkg::nibble_t     wb_data,
    output logic                 flag_en,
    output logic                 wb_carry,
    output logic                 wb_zero,
    output logic                 inc_x,
    output logic                 inc_y,
    output logic                 busy
);
    import adc_pkg::*;

    seq_state_e cur_state;
    op_desc_t   op_q;
    nibble_t    a_q;
    nibble_t    b_q;
    logic       b_mem_q;
    logic       dec_q;
    nibble_t    sum_q;
    logic       carry_q;
    logic       zero_q;
    logic       done_q;
    logic       accept;
    logic       in_write;
    logic       dst_mem;

    function automatic logic is_mem(operand_e op);
        return (op == OP_MX) || (op == OP_MY);
    endfunction

    function automatic addr_t mem_addr_of(operand_e op, arch_state_t st);
        return (op == OP_MY) ? st.y : st.x;
    endfunction

    assign accept      = instr_valid && instr_ready;
    assign instr_ready = (cur_state == S_IDLE);
    assign busy        = (cur_state != S_IDLE);
    assign done        = done_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            cur_state <= S_IDLE;
            done_q    <= 1'b0;
            b_mem_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (cur_state)
                S_IDLE:   if (accept) cur_state <= S_DECODE;
                S_DECODE: cur_state <= S_READ;
                S_READ: begin
                    cur_state <= S_ADD;
                    b_mem_q   <= !op_q.use_imm && is_mem(op_q.src);
                end
                S_ADD: begin
                    cur_state <= S_WRITE;
                    b_mem_q   <= 1'b0;
                end
                S_WRITE:  cur_state <= S_INC;
                S_INC:    cur_state <= S_DONE;
                S_DONE: begin
                    cur_state <= S_IDLE;
                    done_q    <= 1'b1;
                end
                default:  cur_state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            op_q <= desc;
        if (cur_state == S_READ) begin
            // mem_rdata holds the dst word fetched in S_DECODE
            if (op_q.cls == CLS_IDX_IMM) begin
                case (op_q.idx_field)
                    XH:      a_q <= state.x[7:4];
                    XL:      a_q <= state.x[3:0];
                    YH:      a_q <= state.y[7:4];
                    default: a_q <= state.y[3:0];
                endcase
            end else if (is_mem(op_q.dst)) begin
                a_q <= mem_rdata;
            end else begin
                a_q <= (op_q.dst == OP_B) ? state.b : state.a;
            end
            b_q   <= op_q.use_imm ? op_q.imm : ((op_q.src == OP_B) ? state.b : state.a);
            dec_q <= op_q.use_decimal && state.decimal;
        end
        if (cur_state == S_ADD) begin
            if (b_mem_q)
                b_q <= mem_rdata;
            sum_q   <= add_sum;
            carry_q <= add_carry;
            zero_q  <= add_zero;
        end
    end

    // dst word read in S_DECODE, src word in S_READ
    assign mem_raddr   = mem_addr_of((cur_state == S_READ) ? op_q.src : op_q.dst, state);
    assign add_a       = a_q;
    assign add_b       = b_mem_q ? mem_rdata : b_q;  // src word lands during S_ADD
    assign add_decimal = dec_q;

    assign in_write  = (cur_state == S_WRITE);
    assign dst_mem   = is_mem(op_q.dst);
    assign mem_we    = in_write && dst_mem;
    assign mem_waddr = mem_addr_of(op_q.dst, state);  // Index not yet bumped
    assign mem_wdata = sum_q;

    assign wb_en        = in_write && (op_q.cls != CLS_IDX_IMM) && !dst_mem;
    assign wb_dst       = op_q.dst;
    assign wb_idx_en    = in_write && (op_q.cls == CLS_IDX_IMM);
    assign wb_idx_field = op_q.idx_field;
    assign wb_data      = sum_q;
    assign flag_en      = in_write;
    assign wb_carry     = carry_q;
    assign wb_zero      = zero_q;

    assign inc_x = (cur_state == S_INC) && op_q.inc_x;
    assign inc_y = (cur_state == S_INC) && op_q.inc_y;

    assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done held longer than one cycle");

    assert property (@(posedge clk) disable iff (reset) accept |-> desc.cls != CLS_ILLEGAL)
        else $error("illegal instruction word accepted");

endmodule

`default_nettype wire

// File: hdl/adc_core.sv
`timescale 1ns/10ps
`default_nettype none

module adc_core #(
    parameter int MEM_DEPTH = 4096
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  adc_pkg::instr_t      instr,
    output logic                 instr_ready,
    output logic                 done,
    input  logic                 load_valid,
    input  adc_pkg::arch_state_t state_in,
    output adc_pkg::arch_state_t state,
    input  logic                 mem_we,
    input  adc_pkg::addr_t       mem_addr,
    input  adc_pkg::nibble_t     mem_wdata,
    output adc_pkg::nibble_t     mem_rdata
);
    import adc_pkg::*;

    op_desc_t   desc;
    logic       busy;
    addr_t      seq_raddr;
    logic       seq_we;
    addr_t      seq_waddr;
    nibble_t    seq_wdata;
    nibble_t    add_a;
    nibble_t    add_b;
    logic       add_decimal;
    nibble_t    add_sum;
    logic       add_carry;
    logic       add_zero;
    logic       wb_en;
    operand_e   wb_dst;
    logic       wb_idx_en;
    idx_field_e wb_idx_field;
    nibble_t    wb_data;
    logic       flag_en;
    logic       wb_carry;
    logic       wb_zero;
    logic       inc_x;
    logic       inc_y;
    logic       host_load;
    logic       ram_we;
    addr_t      ram_waddr;
    nibble_t    ram_wdata;
    addr_t      ram_raddr;

    // Host owns loads and the RAM port only while idle
    assign host_load = load_valid && !busy;
    assign ram_we    = busy ? seq_we : mem_we;
    assign ram_waddr = busy ? seq_waddr : mem_addr;
    assign ram_wdata = busy ? seq_wdata : mem_wdata;
    assign ram_raddr = busy ? seq_raddr : mem_addr;

    opcode_decoder opcode_decoder_i (.instr, .desc);

    exec_sequencer exec_sequencer_i (
        .clk, .reset, .instr_valid, .instr_ready, .done, .desc, .state,
        .mem_raddr (seq_raddr),
        .mem_rdata (mem_rdata),
        .mem_we    (seq_we),
        .mem_waddr (seq_waddr),
        .mem_wdata (seq_wdata),
        .add_a, .add_b, .add_decimal, .add_sum, .add_carry, .add_zero,
        .wb_en, .wb_dst, .wb_idx_en, .wb_idx_field, .wb_data,
        .flag_en, .wb_carry, .wb_zero, .inc_x, .inc_y, .busy
    );

    bcd_adder bcd_adder_i (
        .a         (add_a),
        .b         (add_b),
        .carry_in  (state.carry),
        .decimal   (add_decimal),
        .sum       (add_sum),
        .carry_out (add_carry),
        .zero      (add_zero)
    );

    register_file register_file_i (
        .clk, .reset, .state_in, .wb_en, .wb_dst, .wb_idx_en, .wb_idx_field,
        .wb_data, .flag_en, .inc_x, .inc_y, .state,
        .load_valid (host_load),
        .carry_in   (wb_carry),
        .zero_in    (wb_zero)
    );

    data_ram #(.MEM_DEPTH(MEM_DEPTH)) data_ram_i (
        .clk,
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .raddr (ram_raddr),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: tb/adc_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module adc_core_tb;
    import adc_pkg::*;

    localparam int MAX_VECTORS = 64;
    localparam int FIELDS      = 9;
    localparam int LATENCY     = 7;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    instr_t      instr;
    logic        instr_ready;
    logic        done;
    logic        load_valid;
    arch_state_t state_in;
    arch_state_t state;
    logic        mem_we;
    addr_t       mem_addr;
    nibble_t     mem_wdata;
    nibble_t     mem_rdata;

    logic [11:0] vec_mem [MAX_VECTORS*FIELDS];
    int          num_vectors;
    int          cycle_limit;
    int          cycle_count;
    int          error_count;
    int          check_count;
    logic [31:0] rnd;

    adc_core adc_core_i (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] v);
        logic [31:0] x;
        x = v;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Result is {carry, sum} and a decimal total of ten or more drops ten and sets carry
    function automatic logic [4:0] nibble_add(input nibble_t a, input nibble_t b,
                                              input logic cin, input logic dec);
        int total;
        total = int'(a) + int'(b) + int'(cin);
        if (dec && total >= 10)
            total = total - 10 + 16;
        return 5'(total);
    endfunction

    function automatic nibble_t operand_value(input logic [1:0] code, input arch_state_t s,
                                              input nibble_t m_x, input nibble_t m_y);
        case (code)
            2'd0:    return s.a;
            2'd1:    return s.b;
            2'd2:    return m_x;
            default: return m_y;
        endcase
    endfunction

    function automatic string state_text(input arch_state_t s);
        return $sformatf("a=%h b=%h x=%h y=%h c=%b z=%b d=%b",
                         s.a, s.b, s.x, s.y, s.carry, s.zero, s.decimal);
    endfunction

    function automatic logic vector_present(input int idx);
        logic [11:0] w;
        w = vec_mem[idx*FIELDS];
        return !$isunknown(w) && (w != 12'h000);
    endfunction

    task automatic predict(input instr_t op, input arch_state_t s, input nibble_t mx_in,
                           input nibble_t my_in, output arch_state_t e,
                           output nibble_t m_x, output nibble_t m_y);
        logic [1:0] dst;
        nibble_t    lhs;
        nibble_t    rhs;
        logic [4:0] res;
        e   = s;
        m_y = my_in;
        m_x = (s.x == s.y) ? my_in : mx_in;  // M(Y) lands last
        if (op[11:6] == 6'b101000) begin
            case (op[5:4])
                2'd0:    lhs = s.x[7:4];
                2'd1:    lhs = s.x[3:0];
                2'd2:    lhs = s.y[7:4];
                default: lhs = s.y[3:0];
            endcase
            res = nibble_add(lhs, op[3:0], s.carry, 1'b0);  // Index nibbles always binary
            case (op[5:4])
                2'd0:    e.x[7:4] = res[3:0];
                2'd1:    e.x[3:0] = res[3:0];
                2'd2:    e.y[7:4] = res[3:0];
                default: e.y[3:0] = res[3:0];
            endcase
        end else begin
            if (op[11:4] == 8'hA9) begin
                dst = op[3:2];
                rhs = operand_value(op[1:0], s, m_x, m_y);
            end else if (op[11:6] == 6'b110001) begin
                dst = op[5:4];
                rhs = op[3:0];
            end else begin
                dst = {1'b1, op[2]};  // ACPX to M(X), ACPY to M(Y)
                rhs = operand_value(op[1:0], s, m_x, m_y);
            end
            res = nibble_add(operand_value(dst, s, m_x, m_y), rhs, s.carry, s.decimal);
            case (dst)
                2'd0:    e.a = res[3:0];
                2'd1:    e.b = res[3:0];
                2'd2:    m_x = res[3:0];
                default: m_y = res[3:0];
            endcase
            if (dst[1] && s.x == s.y) begin
                m_x = res[3:0];
                m_y = res[3:0];
            end
            if (op[11:3] == 9'b111100101) begin
                if (op[2])
                    e.y = e.y + 12'd1;
                else
                    e.x = e.x + 12'd1;
            end
        end
        e.carry = res[4];
        e.zero  = (res[3:0] == 4'd0);
    endtask

    task automatic run_vector(input int idx);
        int          base;
        instr_t      op;
        arch_state_t s;
        arch_state_t exp_state;
        nibble_t     mx;
        nibble_t     my;
        nibble_t     exp_mx;
        nibble_t     exp_my;
        int          cycles;
        logic        finished;
        base      = idx * FIELDS;
        op        = vec_mem[base];
        s         = '0;
        s.a       = vec_mem[base+1][3:0];
        s.b       = vec_mem[base+2][3:0];
        s.x       = vec_mem[base+3];
        s.y       = vec_mem[base+4];
        s.carry   = vec_mem[base+5][0];
        s.decimal = vec_mem[base+6][0];
        mx        = vec_mem[base+7][3:0];
        my        = vec_mem[base+8][3:0];
        if (idx % 6 == 5) begin  // Every sixth vector gets random memory words
            rnd = xorshift(rnd);
            mx  = s.decimal ? (rnd[3:0] % 4'd10) : rnd[3:0];
            rnd = xorshift(rnd);
            my  = s.decimal ? (rnd[3:0] % 4'd10) : rnd[3:0];
        end
        predict(op, s, mx, my, exp_state, exp_mx, exp_my);

        @(negedge clk);
        while (!instr_ready) @(negedge clk);
        @(posedge clk);
        load_valid <= 1'b1;
        state_in   <= s;
        @(posedge clk);
        load_valid <= 1'b0;
        mem_we     <= 1'b1;
        mem_addr   <= s.x;
        mem_wdata  <= mx;
        @(posedge clk);
        mem_addr   <= s.y;
        mem_wdata  <= my;
        @(posedge clk);
        mem_we      <= 1'b0;
        instr_valid <= 1'b1;
        instr       <= op;
        @(negedge clk);
        while (!instr_ready) @(negedge clk);
        @(posedge clk);  // Accepting edge
        instr_valid <= 1'b0;

        cycles   = 0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            cycles++;
            if (done) begin
                finished = 1'b1;
            end else begin
                check_count++;
                if (instr_ready) begin
                    error_count++;
                    $display("FAILED at %0t: vector %0d instr_ready high in busy cycle %0d",
                             $time, idx, cycles);
                end
                @(posedge clk);
                // Host traffic while busy must leave no trace
                load_valid <= (cycles == 2 || cycles == 3);
                state_in   <= ~s;
                mem_we     <= (cycles == 2 || cycles == 3);
                mem_addr   <= s.x;
                mem_wdata  <= ~mx;
            end
        end

        check_count += 3;
        if (cycles != LATENCY) begin
            error_count++;
            $display("FAILED at %0t: vector %0d done after %0d cycles, expected %0d",
                     $time, idx, cycles, LATENCY);
        end
        if (!instr_ready) begin
            error_count++;
            $display("FAILED at %0t: vector %0d instr_ready low with done", $time, idx);
        end
        if (state !== exp_state) begin
            error_count++;
            $display("FAILED at %0t: vector %0d op %h state %s, expected %s", $time, idx, op,
                     state_text(state), state_text(exp_state));
        end

        @(posedge clk);
        mem_addr <= s.x;
        @(posedge clk);
        mem_addr <= s.y;
        @(negedge clk);
        check_count++;
        if (mem_rdata !== exp_mx) begin
            error_count++;
            $display("FAILED at %0t: vector %0d M(%h) is %h, expected %h",
                     $time, idx, s.x, mem_rdata, exp_mx);
        end
        @(posedge clk);
        @(negedge clk);
        check_count++;
        if (mem_rdata !== exp_my) begin
            error_count++;
            $display("FAILED at %0t: vector %0d M(%h) is %h, expected %h",
                     $time, idx, s.y, mem_rdata, exp_my);
        end
    endtask

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the core stopped answering", cycle_count);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        load_valid  = 1'b0;
        state_in    = '0;
        mem_we      = 1'b0;
        mem_addr    = '0;
        mem_wdata   = '0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        cycle_limit = 0;
        rnd         = 32'hd444;

        $readmemh("tb/adc_tests.txt", vec_mem);
        num_vectors = 0;
        while (num_vectors < MAX_VECTORS && vector_present(num_vectors))
            num_vectors++;
        if (num_vectors == 0) begin
            error_count++;
            $display("No test vectors found in tb/adc_tests.txt");
        end
        cycle_limit = 40 * num_vectors + 100;

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < num_vectors; i++)
            run_vector(i);

        $display("Vectors: %0d, checks: %0d, errors: %0d", num_vectors, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/adc_tests.txt
// opcode A B X Y carry decimal M(X) M(Y), all hex
// M(X) is written before M(Y), so M(Y) wins when X equals Y
A05 3 7 0A3 250 1 1 4 9
A1F 0 0 1F7 3C2 0 0 2 6
A23 5 5 123 4B6 0 1 1 1
A3E 1 2 010 FF1 1 0 8 8
A90 4 2 100 200 0 1 3 5
A91 7 6 101 201 1 1 0 0
A92 9 0 102 202 0 0 7 1
A93 5 3 103 203 1 1 2 4
A94 8 9 104 204 0 0 0 0
A95 1 5 105 205 1 1 6 6
A96 0 C 106 206 1 0 3 9
A97 2 3 107 207 0 1 0 0
A98 6 1 108 208 1 1 3 7
A99 0 F 109 209 0 0 E 2
A9A 1 1 10A 10A 0 1 3 4
A9B 2 2 10B 20B 1 0 9 6
A9C 3 4 10C 20C 0 1 1 7
A9D 5 8 10D 20D 1 0 0 0
A9E 0 0 10E 20E 1 1 8 9
A9F 7 7 FFF 000 0 0 5 2
C49 9 0 300 400 1 1 0 0
C57 0 9 301 401 0 0 0 0
C75 1 2 302 402 0 1 3 5
C68 4 4 303 403 1 1 0 0
F28 6 1 FFF 500 0 1 4 2
F2D 0 9 600 FFF 1 0 1 7
F2E 0 0 700 7A5 0 1 2 3

// File: project.f
hdl/adc_pkg.sv
hdl/opcode_decoder.sv
hdl/bcd_adder.sv
hdl/register_file.sv
hdl/data_ram.sv
hdl/exec_sequencer.sv
hdl/adc_core.sv
tb/adc_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the adc_core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert -j 0 --timescale 1ns/10ps \
    --top-module adc_core_tb --Mdir "$build_dir" -o adc_core_sim -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/adc_core_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$log_file"; then
    exit 1
fi
exit 0
